// ==== hmr_tmr.f ====
hdl/hmr_tmr_pkg.sv
hdl/hmr_apb_pkg.sv
hdl/hmr_tmr_voter.sv
hdl/hmr_tmr_regs.sv
hdl/hmr_tmr_ctrl.sv
hdl/hmr_tmr_top.sv
verif/hmr_tmr_properties.sv
verif/hmr_tmr_tb.sv

// ==== verif/hmr_tmr_tb.sv ====
/*
 * Testbench of the TMR group controller: random APB and core stimulus
 * checked against a model of the registers, voters and mode FSM
 */

`timescale 1ns/1ps
`default_nettype none

module hmr_tmr_tb;

  import hmr_tmr_pkg::*;
  import hmr_apb_pkg::*;

  localparam int ClkPeriod    = 8;
  localparam int NumRegWrites = 16;
  localparam int NumVotes     = 64;
  localparam int NumCounts    = 24;
  localparam int NumSatPulses = 260;
  localparam int NumDirected  = 40;
  localparam int TotalTxns    = NumRegWrites * 2 + NumVotes + NumCounts * 2 +
                                NumSatPulses + NumDirected;
  localparam int TimeoutNs    = (TotalTxns * 20 + 1000) * ClkPeriod;

  logic                 clk;
  logic                 rst_n;
  logic [AddrWidth-1:0] paddr;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [DataWidth-1:0] pwdata;
  logic [DataWidth-1:0] prdata;
  logic                 pready;
  logic                 pslverr;
  data_t                core_data [NumCores];
  pc_t                  core_pc [NumCores];
  logic                 fetch_en;
  logic                 cores_synch;
  logic                 sp_zero;
  logic                 sp_will_zero;
  logic                 recovery_finished;
  data_t                voted_data;
  pc_t                  voted_pc;
  logic [2:0]           setback;
  logic                 sw_synch_req;
  logic                 sw_resynch_req;
  logic                 grp_in_independent;
  logic                 recovery_request;

  // Reference model state
  data_t                base_data;
  pc_t                  base_pc;
  logic                 model_enable;
  logic [4:0]           model_cfg;
  tmr_mode_e            model_mode;
  logic [CntWidth-1:0]  model_cnt [NumCores];

  int                   checks;
  int                   errors;
  int                   test_num;
  int                   errors_before;
  int                   synch_pulses;
  int                   resynch_pulses;
  logic [2:0]           setback_seen;
  logic [31:0]          rdata;
  logic                 rerr;
  logic [31:0]          wdata;
  int                   core;

  hmr_tmr_top dut_i (
    .clk_i                   (clk),
    .rst_ni                  (rst_n),
    .paddr_i                 (paddr),
    .psel_i                  (psel),
    .penable_i               (penable),
    .pwrite_i                (pwrite),
    .pwdata_i                (pwdata),
    .prdata_o                (prdata),
    .pready_o                (pready),
    .pslverr_o               (pslverr),
    .core_data0_i            (core_data[0]),
    .core_data1_i            (core_data[1]),
    .core_data2_i            (core_data[2]),
    .core_pc0_i              (core_pc[0]),
    .core_pc1_i              (core_pc[1]),
    .core_pc2_i              (core_pc[2]),
    .fetch_en_i              (fetch_en),
    .cores_synch_i           (cores_synch),
    .sp_store_is_zero_i      (sp_zero),
    .sp_store_will_be_zero_i (sp_will_zero),
    .recovery_finished_i     (recovery_finished),
    .voted_data_o            (voted_data),
    .voted_pc_o              (voted_pc),
    .setback_o               (setback),
    .sw_synch_req_o          (sw_synch_req),
    .sw_resynch_req_o        (sw_resynch_req),
    .grp_in_independent_o    (grp_in_independent),
    .recovery_request_o      (recovery_request)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // Pulse and setback monitor, sampled just before each rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (sw_synch_req) synch_pulses++;
      if (sw_resynch_req) resynch_pulses++;
      if (setback != 3'b000) setback_seen = setback;
    end
  end

  initial begin
    #(TimeoutNs);
    $display("Timeout: the run did not finish in %0d ns", TimeoutNs);
    $display("Some tests failed");
    $finish;
  end

  function automatic logic [31:0] majority(logic [31:0] a, logic [31:0] b, logic [31:0] c);
    if (a == b || a == c) return a;
    if (b == c) return b;
    // No majority, core 0 wins
    return a;
  endfunction

  function automatic logic [CntWidth-1:0] sat_inc(logic [CntWidth-1:0] v);
    return (v == '1) ? v : v + 1'b1;
  endfunction

  task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error: %s = 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  task automatic finish_test(input string name);
    $display("Test %0d %s done with %0d errors", test_num, name, errors - errors_before);
    test_num++;
    errors_before = errors;
  endtask

  task automatic write_reg(input logic [AddrWidth-1:0] addr, input logic [31:0] data);
    @(negedge clk);
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_reg(input logic [AddrWidth-1:0] addr, output logic [31:0] data,
                          output logic err);
    @(negedge clk);
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data = prdata;
    err  = pslverr;
    check("pready_o", pready, 1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic expect_reg(input logic [AddrWidth-1:0] addr, input logic [31:0] expected,
                            input logic [31:0] mask, input string name);
    logic [31:0] data;
    logic        err;
    read_reg(addr, data, err);
    check({"prdata_o ", name}, data & mask, expected & mask);
    check("pslverr_o", err, 0);
  endtask

  // Poll the status register until the expected mode shows up
  task automatic wait_mode(input tmr_mode_e expected);
    logic [31:0] data;
    logic        err;
    int          tries;
    tries = 0;
    data  = '1;
    while (data[2:0] != expected && tries < 20) begin
      read_reg(RegStatus, data, err);
      tries++;
    end
    checks++;
    if (data[2:0] != expected) begin
      errors++;
      $display("Mode never reached %0d, status still reads %0d", expected, data[2:0]);
    end
    model_mode = expected;
  endtask

  // One cycle of disagreement from a single core, on data or PC
  task automatic pulse_mismatch(input int idx);
    logic [31:0] mask;
    mask = $urandom | 32'h1;
    @(negedge clk);
    if ($urandom % 2) core_pc[idx] = base_pc ^ mask[15:0];
    else core_data[idx] = base_data ^ mask;
    @(negedge clk);
    core_data[idx] = base_data;
    core_pc[idx]   = base_pc;
    if (model_mode == TMR_RUN) model_cnt[idx] = sat_inc(model_cnt[idx]);
  endtask

  initial begin
    void'($urandom(10));
    clk = 1'b0;
    rst_n = 1'b0;
    {psel, penable, pwrite, paddr, pwdata} = '0;
    base_data = $urandom;
    base_pc   = $urandom;
    for (int i = 0; i < NumCores; i++) begin
      core_data[i] = base_data;
      core_pc[i]   = base_pc;
      model_cnt[i] = '0;
    end
    fetch_en = 1'b0;
    cores_synch = 1'b0;
    sp_zero = 1'b1;
    sp_will_zero = 1'b0;
    recovery_finished = 1'b0;
    {model_enable, model_cfg} = '0;
    model_mode = DefaultMode;
    {checks, errors, test_num, errors_before, synch_pulses, resynch_pulses} = '0;
    setback_seen = 3'b000;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Registers, fetch still disabled so enable sets the mode directly
    expect_reg(RegStatus, 32'(NON_TMR), 32'h7, "status");
    for (int i = 0; i < NumRegWrites; i++) begin
      wdata = $urandom;
      if ($urandom % 2) begin
        write_reg(RegEnable, wdata);
        model_enable = wdata[0];
        expect_reg(RegEnable, 32'(model_enable), 32'h1, "enable");
      end else begin
        write_reg(RegConfig, wdata);
        model_cfg = wdata[4:0];
        expect_reg(RegConfig, 32'(model_cfg), 32'hF, "config");
      end
    end
    read_reg(8'h18 + 8'($urandom % 232), rdata, rerr);
    check("pslverr_o", rerr, 1);
    write_reg(RegEnable, 0);
    write_reg(RegConfig, 0);
    wait_mode(NON_TMR);
    finish_test("registers");

    // Voting in NON_TMR, where mismatches have no side effect
    for (int i = 0; i < NumVotes; i++) begin
      logic [31:0] d [3];
      logic [15:0] p [3];
      int          bad_d;
      int          bad_p;
      wdata = $urandom;
      bad_d = $urandom % 4;
      bad_p = $urandom % 4;
      for (int c = 0; c < 3; c++) begin
        d[c] = wdata;
        p[c] = wdata[31:16];
      end
      if (bad_d < 3) d[bad_d] = d[bad_d] ^ ($urandom | 32'h1);
      if (bad_p < 3) p[bad_p] = p[bad_p] ^ 16'($urandom | 32'h1);
      for (int c = 0; c < 3; c++) begin
        core_data[c] = d[c];
        core_pc[c]   = p[c];
      end
      @(negedge clk);
      check("voted_data_o", voted_data, majority(d[0], d[1], d[2]));
      check("voted_pc_o", 32'(voted_pc), majority(32'(p[0]), 32'(p[1]), 32'(p[2])));
    end
    for (int c = 0; c < 3; c++) begin
      core_data[c] = base_data;
      core_pc[c]   = base_pc;
    end
    finish_test("voting");

    // Counting in TMR_RUN with resynch held off
    write_reg(RegConfig, 32'(1) << CfgDelayResynch);
    write_reg(RegEnable, 1);
    wait_mode(TMR_RUN);
    @(negedge clk);
    fetch_en = 1'b1;
    for (int i = 0; i < NumCounts; i++) begin
      core = $urandom % 3;
      pulse_mismatch(core);
      if ($urandom % 6 == 0) begin
        write_reg(RegMismatch0 + 8'(4 * core), $urandom);
        model_cnt[core] = '0;
      end
      expect_reg(RegMismatch0 + 8'(4 * core), 32'(model_cnt[core]), 32'hFF,
                 $sformatf("mismatch%0d", core));
    end
    repeat (NumSatPulses) pulse_mismatch(2);
    expect_reg(RegMismatch2, 32'(model_cnt[2]), 32'hFF, "mismatch2");
    write_reg(RegMismatch2, $urandom);
    model_cnt[2] = '0;
    expect_reg(RegMismatch2, 0, 32'hFF, "mismatch2");
    wait_mode(TMR_RUN);
    finish_test("counting");

    // Resynch through unload and reload
    write_reg(RegConfig, 32'(1) << CfgSetback);
    resynch_pulses = 0;
    setback_seen = 3'b000;
    core = $urandom % 3;
    pulse_mismatch(core);
    wait_mode(TMR_UNLOAD);
    check("sw_resynch_req_o pulses", resynch_pulses, 1);
    @(negedge clk);
    sp_zero = 1'b0;
    wait_mode(TMR_RELOAD);
    check("setback_o", setback_seen, 3'b111);
    @(negedge clk);
    sp_zero = 1'b1;
    wait_mode(TMR_RUN);
    expect_reg(RegMismatch0 + 8'(4 * core), 32'(model_cnt[core]), 32'hFF, "mismatch");
    finish_test("resynch");

    // Rapid recovery holds its request until the engine is done
    write_reg(RegConfig, 32'(1) << CfgRapidRecovery);
    core = $urandom % 3;
    pulse_mismatch(core);
    wait_mode(TMR_RAPID);
    repeat (4 + $urandom % 8) @(negedge clk);
    check("recovery_request_o", recovery_request, 1);
    recovery_finished = 1'b1;
    @(negedge clk);
    recovery_finished = 1'b0;
    wait_mode(TMR_RUN);
    check("recovery_request_o", recovery_request, 0);
    expect_reg(RegMismatch0 + 8'(4 * core), 32'(model_cnt[core]), 32'hFF, "mismatch");
    finish_test("rapid");

    // Leave TMR, then come back through synch and reload
    write_reg(RegConfig, 32'(1) << CfgSetback);
    setback_seen = 3'b000;
    write_reg(RegEnable, 0);
    wait_mode(NON_TMR);
    check("grp_in_independent_o", grp_in_independent, 1);
    check("setback_o", setback_seen, 3'b110);
    sp_zero = 1'b0;
    synch_pulses = 0;
    write_reg(RegEnable, 1);
    repeat (4) @(negedge clk);
    check("sw_synch_req_o pulses", synch_pulses, 1);
    setback_seen = 3'b000;
    cores_synch = 1'b1;
    wait_mode(TMR_RELOAD);
    cores_synch = 1'b0;
    check("setback_o", setback_seen, 3'b111);
    check("grp_in_independent_o", grp_in_independent, 0);
    @(negedge clk);
    sp_zero = 1'b1;
    wait_mode(TMR_RUN);
    finish_test("mode switch");

    $display("Tests: %0d, checks: %0d, errors: %0d", test_num, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/hmr_tmr_properties.sv ====
/*
 * Concurrent checks on the APB handshake, the request pulses
 * and the setback codes of the TMR controller
 */

`timescale 1ns/1ps
`default_nettype none

module hmr_tmr_properties (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       psel_i,
  input logic       penable_i,
  input logic       pready_o,
  input logic       sw_synch_req_o,
  input logic       sw_resynch_req_o,
  input logic [2:0] setback_o
);

  // No wait states on the bus
  a_pready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (psel_i && penable_i) |-> pready_o)
    else $error("pready_o low in an APB access phase");

  a_synch_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sw_synch_req_o |=> !sw_synch_req_o)
    else $error("sw_synch_req_o held for two cycles");

  a_resynch_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sw_resynch_req_o |=> !sw_resynch_req_o)
    else $error("sw_resynch_req_o held for two cycles");

  a_req_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(sw_synch_req_o && sw_resynch_req_o))
    else $error("synch and resynch requests in the same cycle");

  // Only full setback or setback of the two followers
  a_setback_code: assert property (@(posedge clk_i) disable iff (!rst_ni)
    setback_o inside {3'b000, 3'b110, 3'b111})
    else $error("setback_o has an illegal code");

endmodule

bind hmr_tmr_top hmr_tmr_properties u_props (.*);

`default_nettype wire

// ==== hdl/hmr_tmr_top.sv ====
/*
 * TMR group controller: data and PC voters, APB registers and
 * the lockstep mode FSM
 */

`timescale 1ns/1ps
`default_nettype none

module hmr_tmr_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // APB slave
  input  logic [hmr_apb_pkg::AddrWidth-1:0]  paddr_i,
  input  logic                               psel_i,
  input  logic                               penable_i,
  input  logic                               pwrite_i,
  input  logic [hmr_apb_pkg::DataWidth-1:0]  pwdata_i,
  output logic [hmr_apb_pkg::DataWidth-1:0]  prdata_o,
  output logic                               pready_o,
  output logic                               pslverr_o,
  // Core results
  input  hmr_tmr_pkg::data_t                 core_data0_i,
  input  hmr_tmr_pkg::data_t                 core_data1_i,
  input  hmr_tmr_pkg::data_t                 core_data2_i,
  input  hmr_tmr_pkg::pc_t                   core_pc0_i,
  input  hmr_tmr_pkg::pc_t                   core_pc1_i,
  input  hmr_tmr_pkg::pc_t                   core_pc2_i,
  // External handshakes
  input  logic                               fetch_en_i,
  input  logic                               cores_synch_i,
  input  logic                               sp_store_is_zero_i,
  input  logic                               sp_store_will_be_zero_i,
  input  logic                               recovery_finished_i,
  output hmr_tmr_pkg::data_t                 voted_data_o,
  output hmr_tmr_pkg::pc_t                   voted_pc_o,
  output logic [2:0]                         setback_o,
  output logic                               sw_synch_req_o,
  output logic                               sw_resynch_req_o,
  output logic                               grp_in_independent_o,
  output logic                               recovery_request_o
);

  import hmr_tmr_pkg::*;

  logic [NumCores-1:0] data_err, pc_err;
  logic                data_fail, pc_fail;
  tmr_mode_e           mode;
  logic                force_resynch_clr;
  logic [NumCores-1:0] incr_mismatch;
  logic                tmr_enable, delay_resynch, setback_en;
  logic                reload_setback_en, rapid_recovery_en, force_resynch;

  hmr_tmr_voter #(
    .payload_t (data_t)
  ) u_data_voter (
    .clk_i,
    .rst_ni,
    .core0_i (core_data0_i),
    .core1_i (core_data1_i),
    .core2_i (core_data2_i),
    .vote_o  (voted_data_o),
    .err_o   (data_err),
    .fail_o  (data_fail)
  );

  hmr_tmr_voter #(
    .payload_t (pc_t)
  ) u_pc_voter (
    .clk_i,
    .rst_ni,
    .core0_i (core_pc0_i),
    .core1_i (core_pc1_i),
    .core2_i (core_pc2_i),
    .vote_o  (voted_pc_o),
    .err_o   (pc_err),
    .fail_o  (pc_fail)
  );

  hmr_tmr_regs u_regs (
    .clk_i,
    .rst_ni,
    .paddr_i,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .pwdata_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .mode_i              (mode),
    .force_resynch_clr_i (force_resynch_clr),
    .incr_mismatch_i     (incr_mismatch),
    .tmr_enable_o        (tmr_enable),
    .delay_resynch_o     (delay_resynch),
    .setback_en_o        (setback_en),
    .reload_setback_en_o (reload_setback_en),
    .rapid_recovery_en_o (rapid_recovery_en),
    .force_resynch_o     (force_resynch)
  );

  hmr_tmr_ctrl u_ctrl (
    .clk_i,
    .rst_ni,
    .tmr_enable_i        (tmr_enable),
    .delay_resynch_i     (delay_resynch),
    .setback_en_i        (setback_en),
    .reload_setback_en_i (reload_setback_en),
    .rapid_recovery_en_i (rapid_recovery_en),
    .force_resynch_i     (force_resynch),
    .data_err_i          (data_err),
    .pc_err_i            (pc_err),
    .data_fail_i         (data_fail),
    .pc_fail_i           (pc_fail),
    .fetch_en_i,
    .cores_synch_i,
    .sp_store_is_zero_i,
    .sp_store_will_be_zero_i,
    .recovery_finished_i,
    .mode_o              (mode),
    .force_resynch_clr_o (force_resynch_clr),
    .incr_mismatch_o     (incr_mismatch),
    .setback_o,
    .sw_synch_req_o,
    .sw_resynch_req_o,
    .grp_in_independent_o,
    .recovery_request_o
  );

endmodule

`default_nettype wire

// ==== hdl/hmr_tmr_ctrl.sv ====
/*
 * Lockstep mode FSM of the TMR group: moves between independent and
 * redundant execution and drives resynch, setback and recovery
 */

`timescale 1ns/1ps
`default_nettype none

module hmr_tmr_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Configuration from the register file
  input  logic                              tmr_enable_i,
  input  logic                              delay_resynch_i,
  input  logic                              setback_en_i,
  input  logic                              reload_setback_en_i,
  input  logic                              rapid_recovery_en_i,
  input  logic                              force_resynch_i,
  // Voter results
  input  logic [hmr_tmr_pkg::NumCores-1:0]  data_err_i,
  input  logic [hmr_tmr_pkg::NumCores-1:0]  pc_err_i,
  input  logic                              data_fail_i,
  input  logic                              pc_fail_i,
  // Core and state store handshakes
  input  logic                              fetch_en_i,
  input  logic                              cores_synch_i,
  input  logic                              sp_store_is_zero_i,
  input  logic                              sp_store_will_be_zero_i,
  input  logic                              recovery_finished_i,
  output hmr_tmr_pkg::tmr_mode_e            mode_o,
  output logic                              force_resynch_clr_o,
  output logic [hmr_tmr_pkg::NumCores-1:0]  incr_mismatch_o,
  output logic [2:0]                        setback_o,
  output logic                              sw_synch_req_o,
  output logic                              sw_resynch_req_o,
  output logic                              grp_in_independent_o,
  output logic                              recovery_request_o
);

  import hmr_tmr_pkg::*;

  tmr_mode_e           mode_d, mode_q;
  logic [NumCores-1:0] err;
  logic                single_mismatch;
  logic                failure;
  logic                synch_req, synch_req_q;
  logic                resynch_req, resynch_req_q;
  logic                cores_synch_q;

  // Both voters report against the same cores
  assign err             = data_err_i | pc_err_i;
  assign single_mismatch = $onehot(err);
  assign failure         = data_fail_i | pc_fail_i;

  assign resynch_req = (mode_q == TMR_UNLOAD);

  // Requests pulse only on entry into the requesting condition
  assign sw_synch_req_o   = synch_req & ~synch_req_q;
  assign sw_resynch_req_o = resynch_req & ~resynch_req_q;

  assign mode_o               = mode_q;
  assign grp_in_independent_o = (mode_q == NON_TMR);
  assign recovery_request_o   = (mode_q == TMR_RAPID);

  always_comb begin
    mode_d              = mode_q;
    setback_o           = 3'b000;
    incr_mismatch_o     = '0;
    force_resynch_clr_o = 1'b0;
    synch_req           = 1'b0;

    case (mode_q)
      TMR_RUN: begin
        if (force_resynch_i || single_mismatch) begin
          force_resynch_clr_o = force_resynch_i;
          if (single_mismatch) begin
            incr_mismatch_o = err;
          end
          if (rapid_recovery_en_i) begin
            mode_d = TMR_RAPID;
          end else if (!delay_resynch_i) begin
            mode_d = TMR_UNLOAD;
          end
        end
      end

      TMR_UNLOAD: begin
        // Store starts filling once the unload is done
        if (!sp_store_is_zero_i) begin
          mode_d = TMR_RELOAD;
          if (setback_en_i) begin
            setback_o = 3'b111;
          end
        end
      end

      TMR_RELOAD: begin
        if (sp_store_is_zero_i) begin
          mode_d = TMR_RUN;
        end else if ((single_mismatch || failure) && setback_en_i &&
                     reload_setback_en_i && !sp_store_will_be_zero_i) begin
          // Error during reload restarts it
          setback_o = 3'b111;
        end
      end

      TMR_RAPID: begin
        if (recovery_finished_i) begin
          mode_d = TMR_RUN;
        end
      end

      NON_TMR: begin
        if (tmr_enable_i) begin
          synch_req = 1'b1;
          if (cores_synch_q) begin
            if (rapid_recovery_en_i) begin
              mode_d = TMR_RAPID;
            end else begin
              mode_d = TMR_RELOAD;
              if (setback_en_i) begin
                setback_o = 3'b111;
              end
            end
          end
        end
      end

      default: mode_d = DefaultMode;
    endcase

    // Before core startup the enable bit sets the mode directly
    if (!fetch_en_i) begin
      synch_req = 1'b0;
      mode_d    = tmr_enable_i ? TMR_RUN : NON_TMR;
    end

    // Leave TMR at any time, the cores keep a correct state
    if (mode_q == TMR_RUN && !tmr_enable_i) begin
      mode_d = NON_TMR;
      if (setback_en_i) begin
        setback_o = 3'b110;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q        <= DefaultMode;
      synch_req_q   <= 1'b0;
      resynch_req_q <= 1'b0;
      cores_synch_q <= 1'b0;
    end else begin
      mode_q        <= mode_d;
      synch_req_q   <= synch_req;
      resynch_req_q <= resynch_req;
      cores_synch_q <= cores_synch_i;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/hmr_tmr_regs.sv ====
/*
 * APB register file of the TMR controller: enable and config bits,
 * mode status and saturating per-core mismatch counters
 */

`timescale 1ns/1ps
`default_nettype none

module hmr_tmr_regs (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // APB slave
  input  logic [hmr_apb_pkg::AddrWidth-1:0]   paddr_i,
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [hmr_apb_pkg::DataWidth-1:0]   pwdata_i,
  output logic [hmr_apb_pkg::DataWidth-1:0]   prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o,
  // From the control FSM
  input  hmr_tmr_pkg::tmr_mode_e              mode_i,
  input  logic                                force_resynch_clr_i,
  input  logic [hmr_tmr_pkg::NumCores-1:0]    incr_mismatch_i,
  // To the control FSM
  output logic                                tmr_enable_o,
  output logic                                delay_resynch_o,
  output logic                                setback_en_o,
  output logic                                reload_setback_en_o,
  output logic                                rapid_recovery_en_o,
  output logic                                force_resynch_o
);

  import hmr_tmr_pkg::*;
  import hmr_apb_pkg::*;

  localparam int unsigned CfgBits = CfgForceResynch + 1;

  logic                  access;
  logic                  wr_en;
  logic                  mapped;
  logic [DataWidth-1:0]  rdata;
  logic                  enable_q;
  logic [CfgBits-1:0]    cfg_q;
  logic [NumCores-1:0]   cnt_sel;
  logic [CntWidth-1:0]   cnt_q [NumCores];

  assign access = psel_i & penable_i;
  assign wr_en  = access & pwrite_i;

  assign cnt_sel[0] = (paddr_i == RegMismatch0);
  assign cnt_sel[1] = (paddr_i == RegMismatch1);
  assign cnt_sel[2] = (paddr_i == RegMismatch2);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= 1'b0;
      cfg_q    <= '0;
    end else begin
      if (force_resynch_clr_i) begin
        cfg_q[CfgForceResynch] <= 1'b0;
      end
      if (wr_en && paddr_i == RegEnable) begin
        enable_q <= pwdata_i[0];
      end
      if (wr_en && paddr_i == RegConfig) begin
        cfg_q <= pwdata_i[CfgBits-1:0];
      end
    end
  end

  // A write of any value clears a counter and wins over an increment
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumCores; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NumCores; i++) begin
        if (wr_en && cnt_sel[i]) begin
          cnt_q[i] <= '0;
        end else if (incr_mismatch_i[i] && cnt_q[i] != '1) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // Read mux and address decode
  always_comb begin
    rdata  = '0;
    mapped = 1'b1;
    case (paddr_i)
      RegEnable:    rdata = DataWidth'(enable_q);
      RegConfig:    rdata = DataWidth'(cfg_q);
      RegStatus:    rdata = DataWidth'(mode_i);
      RegMismatch0: rdata = DataWidth'(cnt_q[0]);
      RegMismatch1: rdata = DataWidth'(cnt_q[1]);
      RegMismatch2: rdata = DataWidth'(cnt_q[2]);
      default:      mapped = 1'b0;
    endcase
  end

  // No wait states
  assign pready_o  = 1'b1;
  assign prdata_o  = access ? rdata : '0;
  assign pslverr_o = access & ~mapped;

  assign tmr_enable_o        = enable_q;
  assign delay_resynch_o     = cfg_q[CfgDelayResynch];
  assign setback_en_o        = cfg_q[CfgSetback];
  assign reload_setback_en_o = cfg_q[CfgReloadSetback];
  assign rapid_recovery_en_o = cfg_q[CfgRapidRecovery] & RapidRecovery;
  assign force_resynch_o     = cfg_q[CfgForceResynch];

endmodule

`default_nettype wire

// ==== hdl/hmr_tmr_voter.sv ====
/*
 * Registered majority voter over three copies of a payload,
 * flags the disagreeing core or a total failure
 */

`timescale 1ns/1ps
`default_nettype none

module hmr_tmr_voter #(
  parameter type payload_t = hmr_tmr_pkg::data_t
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  payload_t   core0_i,
  input  payload_t   core1_i,
  input  payload_t   core2_i,
  output payload_t   vote_o,
  output logic [2:0] err_o,
  output logic       fail_o
);

  logic       eq01, eq02, eq12;
  payload_t   vote_d;
  logic [2:0] err_d;
  logic       fail_d;

  assign eq01 = (core0_i == core1_i);
  assign eq02 = (core0_i == core2_i);
  assign eq12 = (core1_i == core2_i);

  always_comb begin
    vote_d = core0_i;
    err_d  = 3'b000;
    fail_d = 1'b0;
    if (eq01) begin
      err_d[2] = ~eq02;
    end else if (eq02) begin
      err_d[1] = 1'b1;
    end else if (eq12) begin
      vote_d   = core1_i;
      err_d[0] = 1'b1;
    end else begin
      // No two copies agree, pass core 0 through
      fail_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    vote_o <= vote_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_o  <= 3'b000;
      fail_o <= 1'b0;
    end else begin
      err_o  <= err_d;
      fail_o <= fail_d;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/hmr_apb_pkg.sv ====
/*
 * APB register map of the TMR controller: bus widths, register
 * offsets and bit positions inside the config register
 */

`default_nettype none

package hmr_apb_pkg;

  localparam int unsigned AddrWidth = 8;
  localparam int unsigned DataWidth = 32;

  // Register offsets
  localparam logic [AddrWidth-1:0] RegEnable    = 8'h00;
  localparam logic [AddrWidth-1:0] RegConfig    = 8'h04;
  localparam logic [AddrWidth-1:0] RegStatus    = 8'h08;
  localparam logic [AddrWidth-1:0] RegMismatch0 = 8'h0C;
  localparam logic [AddrWidth-1:0] RegMismatch1 = 8'h10;
  localparam logic [AddrWidth-1:0] RegMismatch2 = 8'h14;

  // Config register bits
  localparam int unsigned CfgDelayResynch  = 0;
  localparam int unsigned CfgSetback       = 1;
  localparam int unsigned CfgReloadSetback = 2;
  localparam int unsigned CfgRapidRecovery = 3;
  localparam int unsigned CfgForceResynch  = 4;

endpackage

`default_nettype wire

// ==== hdl/hmr_tmr_pkg.sv ====
/*
 * TMR group definitions: redundancy modes, core count, payload types
 * and the fixed control options of the lockstep controller
 */

`default_nettype none

package hmr_tmr_pkg;

  // Redundancy modes of the core group
  typedef enum logic [2:0] {
    NON_TMR    = 3'd0,
    TMR_RUN    = 3'd1,
    TMR_UNLOAD = 3'd2,
    TMR_RELOAD = 3'd3,
    TMR_RAPID  = 3'd4
  } tmr_mode_e;

  localparam int unsigned NumCores = 3;

  // Payloads compared by the voters
  typedef logic [31:0] data_t;
  typedef logic [15:0] pc_t;

  // Rapid recovery hardware is present
  localparam bit RapidRecovery = 1'b1;

  localparam tmr_mode_e DefaultMode = NON_TMR;

  // Mismatch counters saturate at all ones
  localparam int unsigned CntWidth = 8;

endpackage

`default_nettype wire
